/* dv/tb_checker.sv */
/*
  result checker for the execution slice
  expected writeback queue, done timing, field compares
*/
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
  input  wire                clk,
  input  wire                rst,
  input  wire                done,
  input  wire exec_pkg::wb_t done_info,
  input  wire                exp_valid,
  input  wire exec_pkg::wb_t exp_info,
  input  wire                end_check,
  output int                 errors,
  output int                 checked,
  output int                 pending
);

  exec_pkg::wb_t exp_q[$];
  exec_pkg::wb_t staged_info;
  logic          staged_valid;
  logic          done_due;
  logic          end_seen;

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("Fail %s: got %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  // entry captured at the sampling edge, its done is due one edge later
  always @(posedge clk) begin
    if (rst) begin
      staged_valid <= 1'b0;
      done_due     <= 1'b0;
    end else begin
      staged_valid <= exp_valid;
      done_due     <= staged_valid;
    end
    staged_info <= exp_info;
  end

  // outputs are stable here, half a cycle after the edge
  always @(negedge clk) begin : compare
    exec_pkg::wb_t want;
    if (rst) begin
      exp_q.delete();
      errors   = 0;
      checked  = 0;
      end_seen = 1'b0;
    end else begin
      if (done && exp_q.size() == 0) begin
        $display("%0t: done pulse with no instruction outstanding", $time);
        errors++;
      end else if (done) begin
        want = exp_q.pop_front();
        checked++;
        compare_field("done_info.rd", {28'd0, done_info.rd}, {28'd0, want.rd});
        compare_field("done_info.data", done_info.data, want.data);
        compare_field("done_info.flags", {28'd0, done_info.flags}, {28'd0, want.flags});
        compare_field("done_info.executed", {31'd0, done_info.executed},
                      {31'd0, want.executed});
      end
      if (done_due && !done) begin
        $display("%0t: no done pulse one cycle after an issued instruction", $time);
        errors++;
        if (exp_q.size() != 0) begin
          want = exp_q.pop_front();
        end
      end
      if (done && !done_due) begin
        $display("%0t: done pulse without an instruction issued one cycle earlier", $time);
        errors++;
      end
      if (staged_valid) begin
        exp_q.push_back(staged_info);
      end
      if (end_check && !end_seen) begin
        end_seen = 1'b1;
        if (exp_q.size() != 0) begin
          $display("%0d expected results were never reported by the DUT", exp_q.size());
          errors++;
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
/*
  testbench clock and reset
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held over two rising edges
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
/*
  testbench top for the execution slice
  DUT, xorshift stimulus, reference model, timeout
*/
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  localparam int num_insns  = 2000;
  localparam int max_cycles = num_insns * 2 + 50;

  logic             clk;
  logic             rst;
  logic             insn_valid;
  exec_pkg::insn_t  insn;
  logic             done;
  exec_pkg::wb_t    done_info;
  logic             exp_valid;
  exec_pkg::wb_t    exp_info;
  logic             end_check;
  int               errors;
  int               checked;
  int               pending;
  int               cycle_count;
  logic [31:0]      rng_state;
  logic [31:0]      model_regs [exec_pkg::num_regs];
  exec_pkg::flags_t model_flags;

  tb_clock clk0 (
    .clk (clk),
    .rst (rst)
  );

  exec_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .done       (done),
    .done_info  (done_info)
  );

  tb_checker chk0 (
    .clk       (clk),
    .rst       (rst),
    .done      (done),
    .done_info (done_info),
    .exp_valid (exp_valid),
    .exp_info  (exp_info),
    .end_check (end_check),
    .errors    (errors),
    .checked   (checked),
    .pending   (pending)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // conditions come in pairs, the odd code inverts the even one
  function automatic logic cond_passes(input logic [3:0] code, input exec_pkg::flags_t f);
    logic base;
    case (code[3:1])
      3'd0:    base = f.zero;
      3'd1:    base = f.carry;
      3'd2:    base = f.sign;
      3'd3:    base = f.overflow;
      3'd4:    base = f.carry && !f.zero;
      3'd5:    base = (f.sign == f.overflow);
      3'd6:    base = (f.sign == f.overflow) && !f.zero;
      default: base = 1'b1;
    endcase
    return base ^ code[0];
  endfunction

  // reference model, updated in program order
  task automatic run_model(input exec_pkg::insn_t in, output exec_pkg::wb_t wb);
    logic [31:0]      imm;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      res;
    logic [32:0]      wide;
    exec_pkg::flags_t f;
    imm = {{16{in.imm[15]}}, in.imm};
    a   = model_regs[in.ra];
    b   = (in.opcode == exec_pkg::op_addi) ? imm : model_regs[in.rb];
    f   = '0;
    case (in.opcode)
      exec_pkg::op_add, exec_pkg::op_addi: begin
        wide       = {1'b0, a} + {1'b0, b};
        res        = wide[31:0];
        f.carry    = wide[32];
        f.overflow = (a[31] == b[31]) && (res[31] != a[31]);
      end
      exec_pkg::op_sub: begin
        res        = a - b;
        f.carry    = (a >= b);
        f.overflow = (a[31] != b[31]) && (res[31] != a[31]);
      end
      exec_pkg::op_and: res = a & b;
      exec_pkg::op_or:  res = a | b;
      exec_pkg::op_xor: res = a ^ b;
      exec_pkg::op_shl: res = a << b[4:0];
      exec_pkg::op_shr: res = a >> b[4:0];
      exec_pkg::op_sar: res = $signed(a) >>> b[4:0];
      default:          res = imm;
    endcase
    f.zero = (res == 32'd0);
    f.sign = res[31];
    wb.rd  = in.rd;
    if (cond_passes(in.cond, model_flags)) begin
      model_regs[in.rd] = res;
      model_flags       = f;
      wb.data           = res;
      wb.flags          = f;
      wb.executed       = 1'b1;
    end else begin
      wb.data     = '0;
      wb.flags    = model_flags;
      wb.executed = 1'b0;
    end
  endtask

  task automatic drive_slot(input logic valid, input exec_pkg::insn_t in);
    exec_pkg::wb_t wb;
    @(negedge clk);
    insn_valid = valid;
    insn       = in;
    exp_valid  = valid;
    if (valid) begin
      run_model(in, wb);
      exp_info = wb;
    end
  endtask

  initial begin : stimulus
    exec_pkg::insn_t in;
    logic [31:0]     r1;
    logic [31:0]     r2;
    logic            slot_valid;
    int              issued;
    insn_valid  = 1'b0;
    insn        = '0;
    exp_valid   = 1'b0;
    exp_info    = '0;
    end_check   = 1'b0;
    rng_state   = 32'd2648;
    model_flags = '0;
    issued      = 0;
    for (int i = 0; i < exec_pkg::num_regs; i++) begin
      model_regs[i] = '0;
    end
    wait (!rst);
    // every register reads zero before the first write
    for (int i = 0; i < exec_pkg::num_regs; i++) begin
      in        = '0;
      in.opcode = exec_pkg::op_add;
      in.cond   = exec_pkg::al;
      in.rd     = 4'(i);
      in.ra     = 4'(i);
      in.rb     = 4'(i);
      drive_slot(1'b1, in);
      issued++;
    end
    while (issued < num_insns) begin
      rng_state  = xorshift32(rng_state);
      r1         = rng_state;
      rng_state  = xorshift32(rng_state);
      r2         = rng_state;
      in         = exec_pkg::insn_t'({r1[3:0], r2});
      slot_valid = (r1[9:8] != 2'b00);
      drive_slot(slot_valid, in);
      if (slot_valid) begin
        issued++;
      end
    end
    @(negedge clk);
    insn_valid = 1'b0;
    exp_valid  = 1'b0;
    @(posedge clk);
    wait (pending == 0);
    @(negedge clk);
    end_check = 1'b1;
    @(negedge clk);
    @(posedge clk);
    $display("checked %0d results, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycle_count);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the execution slice testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_top -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

/* verilog.f */
verilog/exec_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/exec_control.sv
verilog/exec_top.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

/* verilog/alu.sv */
/*
  integer alu of the slice
  operand select, add/sub, logic, shifts, flag generation
*/
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  wire exec_pkg::insn_t          cur,
  input  wire [exec_pkg::data_w-1:0]    ra_data,
  input  wire [exec_pkg::data_w-1:0]    rb_data,
  output logic [exec_pkg::data_w-1:0]   result,
  output exec_pkg::flags_t              new_flags
);

  logic [exec_pkg::data_w-1:0]  imm_ext;
  logic [exec_pkg::data_w-1:0]  opb;
  logic [exec_pkg::data_w-1:0]  opb_eff;
  logic                         uses_rb;
  logic                         is_sub;
  logic                         is_arith;
  logic [exec_pkg::data_w:0]    sum;
  logic [exec_pkg::shamt_w-1:0] shamt;

  assign imm_ext = {{(exec_pkg::data_w - exec_pkg::imm_w){cur.imm[exec_pkg::imm_w-1]}},
                    cur.imm};

  assign uses_rb = cur.opcode inside {exec_pkg::op_add, exec_pkg::op_sub, exec_pkg::op_and,
                                      exec_pkg::op_or, exec_pkg::op_xor, exec_pkg::op_shl,
                                      exec_pkg::op_shr, exec_pkg::op_sar};
  assign opb     = uses_rb ? rb_data : imm_ext;

  assign is_sub   = (cur.opcode == exec_pkg::op_sub);
  assign is_arith = cur.opcode inside {exec_pkg::op_add, exec_pkg::op_sub, exec_pkg::op_addi};

  // sub as a + ~b + 1, carry out is then "no borrow"
  assign opb_eff = is_sub ? ~opb : opb;
  assign sum     = {1'b0, ra_data} + {1'b0, opb_eff} + {{exec_pkg::data_w{1'b0}}, is_sub};

  assign shamt = rb_data[exec_pkg::shamt_w-1:0];

  always_comb begin
    case (cur.opcode)
      exec_pkg::op_add,
      exec_pkg::op_sub,
      exec_pkg::op_addi: result = sum[exec_pkg::data_w-1:0];
      exec_pkg::op_and:  result = ra_data & opb;
      exec_pkg::op_or:   result = ra_data | opb;
      exec_pkg::op_xor:  result = ra_data ^ opb;
      exec_pkg::op_shl:  result = ra_data << shamt;
      exec_pkg::op_shr:  result = ra_data >> shamt;
      exec_pkg::op_sar:  result = $signed(ra_data) >>> shamt;
      default:           result = imm_ext;
    endcase
  end

  assign new_flags.zero  = (result == '0);
  assign new_flags.sign  = result[exec_pkg::data_w-1];
  assign new_flags.carry = is_arith && sum[exec_pkg::data_w];

  // signed overflow: same-sign operands, result sign flipped
  assign new_flags.overflow = is_arith &&
                              (ra_data[exec_pkg::data_w-1] == opb_eff[exec_pkg::data_w-1]) &&
                              (result[exec_pkg::data_w-1] != ra_data[exec_pkg::data_w-1]);

endmodule

`default_nettype wire

/* verilog/exec_control.sv */
/*
  decode register, flag register and condition test
  register file write port and done reporting
*/
`timescale 1ns/1ns
`default_nettype none

module exec_control (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              insn_valid,
  input  wire exec_pkg::insn_t             insn,
  output exec_pkg::insn_t                  cur,
  output logic                             cur_valid,
  input  wire [exec_pkg::data_w-1:0]       result,
  input  wire exec_pkg::flags_t            new_flags,
  output logic                             we,
  output logic [exec_pkg::reg_addr_w-1:0]  waddr,
  output logic [exec_pkg::data_w-1:0]      wdata,
  output logic                             done,
  output exec_pkg::wb_t                    done_info
);

  exec_pkg::flags_t flags;
  logic             cond_ok;

  function automatic logic cond_holds(input exec_pkg::cond_e cond,
                                      input exec_pkg::flags_t f);
    logic sv_eq;
    logic res;
    sv_eq = (f.sign == f.overflow);
    case (cond)
      exec_pkg::eq: res = f.zero;
      exec_pkg::ne: res = !f.zero;
      exec_pkg::cs: res = f.carry;
      exec_pkg::cc: res = !f.carry;
      exec_pkg::mi: res = f.sign;
      exec_pkg::pl: res = !f.sign;
      exec_pkg::vs: res = f.overflow;
      exec_pkg::vc: res = !f.overflow;
      exec_pkg::hi: res = f.carry && !f.zero;
      exec_pkg::ls: res = !(f.carry && !f.zero);
      exec_pkg::ge: res = sv_eq;
      exec_pkg::lt: res = !sv_eq;
      exec_pkg::gt: res = sv_eq && !f.zero;
      exec_pkg::le: res = !(sv_eq && !f.zero);
      exec_pkg::al: res = 1'b1;
      default:      res = 1'b0;
    endcase
    return res;
  endfunction

  // decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      cur_valid <= 1'b0;
    end else begin
      cur_valid <= insn_valid;
    end
    if (insn_valid) begin
      cur <= insn;
    end
  end

  // flags seen here are already updated by the previous instruction
  assign cond_ok = cond_holds(cur.cond, flags);

  assign we    = cur_valid && cond_ok;
  assign waddr = cur.rd;
  assign wdata = result;

  // flag register and done strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
      done  <= 1'b0;
    end else begin
      if (we) begin
        flags <= new_flags;
      end
      done <= cur_valid;
    end
  end

  // skipped instruction reports zero data and the old flags
  always_ff @(posedge clk) begin
    if (cur_valid) begin
      done_info.rd       <= cur.rd;
      done_info.data     <= we ? result : '0;
      done_info.flags    <= we ? new_flags : flags;
      done_info.executed <= we;
    end
  end

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
/*
  shared definitions for the execution slice
  widths and register count, opcode and condition encodings,
  instruction, flag and writeback structs
*/
`default_nettype none

package exec_pkg;

  localparam int data_w     = 32;
  localparam int reg_addr_w = 4;
  localparam int imm_w      = 16;
  localparam int num_regs   = 1 << reg_addr_w;
  localparam int shamt_w    = $clog2(data_w);

  // codes 10..15 are reserved and behave as op_movi
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_shl  = 4'd5,
    op_shr  = 4'd6,
    op_sar  = 4'd7,
    op_addi = 4'd8,
    op_movi = 4'd9
  } opcode_e;

  // odd codes are the inverse of the code below them
  typedef enum logic [3:0] {
    eq = 4'd0,
    ne = 4'd1,
    cs = 4'd2,
    cc = 4'd3,
    mi = 4'd4,
    pl = 4'd5,
    vs = 4'd6,
    vc = 4'd7,
    hi = 4'd8,
    ls = 4'd9,
    ge = 4'd10,
    lt = 4'd11,
    gt = 4'd12,
    le = 4'd13,
    al = 4'd14,
    nv = 4'd15
  } cond_e;

  typedef struct packed {
    opcode_e               opcode;
    cond_e                 cond;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] ra;
    logic [reg_addr_w-1:0] rb;
    logic [imm_w-1:0]      imm;
  } insn_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic sign;
    logic overflow;
  } flags_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [data_w-1:0]     data;
    flags_t                flags;
    logic                  executed;
  } wb_t;

endpackage

`default_nettype wire

/* verilog/exec_top.sv */
/*
  top of the predicated execution slice
  control, register file and alu
*/
`timescale 1ns/1ns
`default_nettype none

module exec_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   insn_valid,
  input  wire exec_pkg::insn_t  insn,
  output logic                  done,
  output exec_pkg::wb_t         done_info
);

  exec_pkg::insn_t                 cur;
  logic [exec_pkg::data_w-1:0]     ra_data;
  logic [exec_pkg::data_w-1:0]     rb_data;
  logic [exec_pkg::data_w-1:0]     result;
  exec_pkg::flags_t                new_flags;
  logic                            we;
  logic [exec_pkg::reg_addr_w-1:0] waddr;
  logic [exec_pkg::data_w-1:0]     wdata;

  exec_control u_control (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .cur        (cur),
    .cur_valid  (),
    .result     (result),
    .new_flags  (new_flags),
    .we         (we),
    .waddr      (waddr),
    .wdata      (wdata),
    .done       (done),
    .done_info  (done_info)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .ra_addr (cur.ra),
    .rb_addr (cur.rb),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .we      (we),
    .waddr   (waddr),
    .wdata   (wdata)
  );

  alu u_alu (
    .cur       (cur),
    .ra_data   (ra_data),
    .rb_data   (rb_data),
    .result    (result),
    .new_flags (new_flags)
  );

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
/*
  16 x 32 register file
  two combinational read ports, one write port
*/
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  wire                              clk,
  input  wire                              rst,
  input  wire [exec_pkg::reg_addr_w-1:0]   ra_addr,
  input  wire [exec_pkg::reg_addr_w-1:0]   rb_addr,
  output logic [exec_pkg::data_w-1:0]      ra_data,
  output logic [exec_pkg::data_w-1:0]      rb_data,
  input  wire                              we,
  input  wire [exec_pkg::reg_addr_w-1:0]   waddr,
  input  wire [exec_pkg::data_w-1:0]       wdata
);

  logic [exec_pkg::data_w-1:0] regs [exec_pkg::num_regs];

  // no bypass, write lands at the edge before the next read
  assign ra_data = regs[ra_addr];
  assign rb_data = regs[rb_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < exec_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire
